// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_phy_mgmt
FILELIST  = filelist.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== filelist.f ====
src/mdio_pkg.sv
src/phy_reg_pkg.sv
src/mdc_clock_gen.sv
src/mdio_frame_engine.sv
src/phy_reg_glue.sv
src/phy_mgmt_top.sv
sim/phy_mdio_model.sv
sim/phy_mgmt_checker.sv
sim/phy_mgmt_sva.sv
sim/tb_phy_mgmt.sv

// ==== sim/phy_mdio_model.sv ====
// Behavioral quad PHY
// Four register files of 32 words answering clause-22 frames
`timescale 1ns/1ps

module phy_mdio_model (
   input  logic mdc,
   input  logic mdio_out,
   input  logic mdio_oe,
   output logic mdio_in
);

   logic [15:0] regs [0:127];
   logic [31:0] shift_in   = '0;
   int          bit_idx    = 0;
   logic        frame_rd   = 1'b0;
   logic [6:0]  frame_addr = '0;
   // Line idles high as with a pull-up
   logic        drive_bit  = 1'b1;

   function automatic logic [15:0] power_on_value(input logic [6:0] idx);
      return {idx, ~idx, 2'b01};
   endfunction

   initial begin
      for (int i = 0; i < 128; i++) begin
         regs[i] = power_on_value(7'(i));
      end
   end

   assign mdio_in = drive_bit;

   // Controller bits are sampled on MDC rising edges
   // A frame starts on the first driven bit after idle
   always @(posedge mdc) begin
      if (bit_idx > 0 || mdio_oe) begin
         shift_in = {shift_in[30:0], mdio_out};
         bit_idx  = bit_idx + 1;
         if (bit_idx == 14) begin
            // start, op, pad, PHY, register
            frame_rd   = (shift_in[11:10] == 2'b10);
            frame_addr = shift_in[6:0];
         end
         if (bit_idx == 32) begin
            if (!frame_rd) begin
               regs[frame_addr] = shift_in[15:0];
            end
            bit_idx = 0;
         end
      end
   end

   // Read data goes out on falling edges, MSB first
   always @(negedge mdc) begin
      if (bit_idx >= 16 && frame_rd) begin
         drive_bit <= regs[frame_addr][31 - bit_idx];
      end else begin
         drive_bit <= 1'b1;
      end
   end

endmodule

// ==== sim/phy_mgmt_checker.sv ====
// Testbench checker
// Compares acked read data, decodes frames on the pins, times MDC
`timescale 1ns/1ps

module phy_mgmt_checker #(
   parameter int mdc_half = 5
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   req,
   input  phy_reg_pkg::reg_req_t  reg_req,
   input  logic                   ack,
   input  phy_reg_pkg::reg_data_t rd_data,
   input  phy_reg_pkg::reg_data_t exp_rd_data,
   input  logic                   mdc,
   input  logic                   mdio_out,
   input  logic                   mdio_oe,
   output int                     errors,
   output int                     checks,
   output int                     frames
);

   int                    bus_errors   = 0;
   int                    frame_errors = 0;
   int                    ack_cnt      = 0;
   int                    valid_acks   = 0;
   int                    frames_done  = 0;
   int                    bit_idx      = 0;
   int                    mdc_cycles   = 0;
   logic                  mdc_q        = 1'b0;
   logic                  mdc_seen     = 1'b0;
   logic [31:0]           frame        = '0;
   phy_reg_pkg::reg_req_t frame_req    = '0;

   assign errors = bus_errors + frame_errors;
   assign checks = ack_cnt;
   assign frames = frames_done;

   // Expected wire image of a clause-22 frame
   task automatic check_frame(input logic [31:0] f, input phy_reg_pkg::reg_req_t r);
      logic [31:0] exp;
      exp = {2'b01, (r.rd ? 2'b10 : 2'b01), 3'b000, r.addr[6:0], 2'b10, r.wdata[15:0]};
      // Turnaround and data of a read are not driven by the controller
      if (r.rd) begin
         exp[17:0] = f[17:0];
      end
      if (f !== exp) begin
         $display("FAIL %0t: frame 0x%08h, expected 0x%08h", $time, f, exp);
         frame_errors++;
      end
   endtask

   always @(posedge clk) begin
      if (reset) begin
         mdc_q      <= 1'b0;
         mdc_seen   <= 1'b0;
         mdc_cycles <= 0;
      end else begin
         if (ack) begin
            ack_cnt++;
            if (!req) begin
               $display("Ack at %0t while no request was pending", $time);
               bus_errors++;
            end else if (rd_data !== exp_rd_data) begin
               $display("FAIL %0t: addr 0x%02h rd_data 0x%08h, expected 0x%08h",
                        $time, reg_req.addr, rd_data, exp_rd_data);
               bus_errors++;
            end
            // Each in-range request owns exactly one frame
            if (reg_req.addr < 8'd128) begin
               valid_acks++;
               if (frames_done != valid_acks) begin
                  $display("FAIL %0t: %0d frames for %0d in-range acks",
                           $time, frames_done, valid_acks);
                  bus_errors++;
               end
            end
         end
         // MDC period between rising edges
         mdc_q <= mdc;
         if (mdc && !mdc_q) begin
            mdc_seen   <= 1'b1;
            mdc_cycles <= 1;
            if (mdc_seen && mdc_cycles != 2 * mdc_half) begin
               $display("FAIL %0t: MDC period %0d cycles", $time, mdc_cycles);
               bus_errors++;
            end
         end else begin
            mdc_cycles <= mdc_cycles + 1;
         end
      end
   end

   // Frame decode on the pins, sampled as the PHY sees them
   always @(posedge mdc) begin
      if (bit_idx == 0 && mdio_oe) begin
         frame_req = reg_req;
         if (!req || reg_req.addr >= 8'd128) begin
            $display("Frame started at %0t without an in-range request", $time);
            frame_errors++;
         end
      end
      if (bit_idx > 0 || mdio_oe) begin
         frame   = {frame[30:0], mdio_out};
         bit_idx = bit_idx + 1;
      end
      if (bit_idx == 32) begin
         bit_idx = 0;
         frames_done++;
         check_frame(frame, frame_req);
      end
   end

endmodule

// ==== sim/phy_mgmt_sva.sv ====
// Bound assertions for the PHY management top level
// Ack width, line release on reads and MDC level in reset
`timescale 1ns/1ps

module phy_mgmt_sva (
   input logic                clk,
   input logic                reset,
   input logic                ack,
   input logic                busy,
   input mdio_pkg::mdio_cmd_t cmd,
   input logic                mdc,
   input logic                mdio_oe
);

   logic mdc_q        = 1'b0;
   logic oe_q         = 1'b0;
   int   falls        = 0;
   int   assert_fails = 0;

   // MDC falls since the first driven bit of the frame
   always @(posedge clk) begin
      mdc_q <= mdc;
      oe_q  <= mdio_oe;
      if (!busy || (mdio_oe && !oe_q)) begin
         falls <= 0;
      end else if (mdc_q && !mdc) begin
         falls <= falls + 1;
      end
   end

   // Single-cycle ack
   ack_one_cycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
      else begin
         $error("ack held for more than one cycle");
         assert_fails++;
      end

   // Bit 14 onward is turnaround and data
   read_release: assert property (@(posedge clk) disable iff (reset)
      (busy && cmd.op == mdio_pkg::op_read && falls >= 14) |-> !mdio_oe)
      else begin
         $error("mdio_oe driven during read turnaround or data");
         assert_fails++;
      end

   mdc_low_in_reset: assert property (@(posedge clk) reset |=> !mdc)
      else begin
         $error("mdc high during reset");
         assert_fails++;
      end

endmodule

bind phy_mgmt_top phy_mgmt_sva u_sva (
   .clk     (clk),
   .reset   (reset),
   .ack     (ack),
   .busy    (busy),
   .cmd     (cmd),
   .mdc     (mdc),
   .mdio_oe (mdio_oe)
);

// ==== sim/tb_phy_mgmt.sv ====
// Testbench top for the PHY management block
// Clock, reset, LCG stimulus, reference model and the final verdict
`timescale 1ns/1ps

module tb_phy_mgmt;

   localparam int mdc_half    = 5;
   localparam int ack_timeout = 2000;

   logic                   clk;
   logic                   reset;
   logic                   req;
   phy_reg_pkg::reg_req_t  reg_req;
   logic                   ack;
   phy_reg_pkg::reg_data_t rd_data;
   logic                   mdc;
   logic                   mdio_out;
   logic                   mdio_oe;
   logic                   mdio_in;
   phy_reg_pkg::reg_data_t exp_rd_data;
   int                     errors;
   int                     acks;
   int                     frames;
   int                     total_errors;
   logic [31:0]            rng;
   // Shadow of the four PHY register files
   logic [15:0]            shadow [0:127];

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Power-on pattern built from PHY and register number together
   function automatic logic [15:0] power_on_value(input logic [6:0] idx);
      return {idx, ~idx, 2'b01};
   endfunction

   // Expected rd_data for one request
   // Writes also update the shadow
   function automatic phy_reg_pkg::reg_data_t expected_response(
      input logic rd, input phy_reg_pkg::reg_addr_t addr, input phy_reg_pkg::reg_data_t wdata);
      phy_reg_pkg::reg_data_t resp;
      if (addr >= 8'd128) begin
         resp = 32'hDEAD_BEEF;
      end else if (rd) begin
         resp = {16'h0000, shadow[addr[6:0]]};
      end else begin
         shadow[addr[6:0]] = wdata[15:0];
         resp = '0;
      end
      return resp;
   endfunction

   task automatic report_timeout(input phy_reg_pkg::reg_addr_t addr);
      $display("No ack within %0d cycles for address 0x%02h at %0t", ack_timeout, addr, $time);
      $display("TEST FAIL");
      $finish;
   endtask

   // One request held until ack and then released
   task automatic issue_request(input logic rd, input phy_reg_pkg::reg_addr_t addr,
                                input phy_reg_pkg::reg_data_t wdata);
      phy_reg_pkg::reg_req_t r;
      int                    waited;
      r.rd    = rd;
      r.addr  = addr;
      r.wdata = wdata;
      waited  = 0;
      @(posedge clk);
      req         <= 1'b1;
      reg_req     <= r;
      exp_rd_data <= expected_response(rd, addr, wdata);
      do begin
         @(posedge clk);
         waited++;
      end while (!ack && waited < ack_timeout);
      if (ack) begin
         req <= 1'b0;
      end else begin
         report_timeout(addr);
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      phy_reg_pkg::reg_addr_t addr;
      reset       = 1'b1;
      req         = 1'b0;
      reg_req     = '0;
      exp_rd_data = '0;
      rng         = 32'h86d3209e;
      for (int i = 0; i < 128; i++) begin
         shadow[i] = power_on_value(7'(i));
      end
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      // Untouched registers still hold their power-on pattern
      repeat (4) begin
         rng = lcg_next(rng);
         issue_request(1'b1, {1'b0, rng[22:16]}, '0);
      end
      // Write then read back at the same address
      repeat (4) begin
         rng  = lcg_next(rng);
         addr = {1'b0, rng[22:16]};
         rng  = lcg_next(rng);
         issue_request(1'b0, addr, rng);
         issue_request(1'b1, addr, '0);
      end
      // Outside the PHY window and so without a frame
      issue_request(1'b1, 8'd128, '0);
      issue_request(1'b0, 8'hFF, 32'h1234_5678);
      rng = lcg_next(rng);
      issue_request(1'b1, {1'b1, rng[22:16]}, '0);
      // Random mix with about a quarter out of range
      repeat (40) begin
         rng  = lcg_next(rng);
         addr = {rng[27] & rng[26], rng[22:16]};
         issue_request(rng[31], addr, lcg_next(rng));
      end
      repeat (10) @(posedge clk);
      total_errors = errors + dut.u_sva.assert_fails;
      $display("Checked %0d acks and %0d frames, %0d errors", acks, frames, total_errors);
      if (total_errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   phy_mgmt_top #(
      .mdc_half (mdc_half)
   ) dut (
      .clk      (clk),
      .reset    (reset),
      .req      (req),
      .reg_req  (reg_req),
      .ack      (ack),
      .rd_data  (rd_data),
      .mdc      (mdc),
      .mdio_out (mdio_out),
      .mdio_oe  (mdio_oe),
      .mdio_in  (mdio_in)
   );

   phy_mdio_model phy (
      .mdc      (mdc),
      .mdio_out (mdio_out),
      .mdio_oe  (mdio_oe),
      .mdio_in  (mdio_in)
   );

   phy_mgmt_checker #(
      .mdc_half (mdc_half)
   ) chk (
      .clk         (clk),
      .reset       (reset),
      .req         (req),
      .reg_req     (reg_req),
      .ack         (ack),
      .rd_data     (rd_data),
      .exp_rd_data (exp_rd_data),
      .mdc         (mdc),
      .mdio_out    (mdio_out),
      .mdio_oe     (mdio_oe),
      .errors      (errors),
      .checks      (acks),
      .frames      (frames)
   );

endmodule

// ==== src/mdc_clock_gen.sv ====
// MDC generator
// Divides clk down to the slow management clock and emits edge strobes
`timescale 1ns/1ps

module mdc_clock_gen #(
   parameter int mdc_half = 5
) (
   input  logic clk,
   input  logic reset,
   output logic mdc,
   output logic mdc_rise,
   output logic mdc_fall
);

   localparam int cnt_w = $clog2(2 * mdc_half + 1);

   logic [cnt_w-1:0] cnt;

   // Counts 1 .. 2*mdc_half
   // Starting at 1 keeps the period exact from the first cycle after reset
   always_ff @(posedge clk) begin
      if (reset || cnt == cnt_w'(2 * mdc_half)) begin
         cnt <= cnt_w'(1);
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

   // One-cycle strobes, one clock behind the count match
   always_ff @(posedge clk) begin
      if (reset) begin
         mdc_rise <= 1'b0;
         mdc_fall <= 1'b0;
         mdc      <= 1'b0;
      end else begin
         mdc_rise <= (cnt == cnt_w'(mdc_half));
         mdc_fall <= (cnt == cnt_w'(2 * mdc_half));
         // Pin level trails the strobes by one more clock
         if (mdc_rise) begin
            mdc <= 1'b1;
         end else if (mdc_fall) begin
            mdc <= 1'b0;
         end
      end
   end

endmodule

// ==== src/mdio_frame_engine.sv ====
// MDIO frame engine
// Serializes one clause-22 frame per command on MDC falling edges,
// drives the output enable and collects read data on MDC rising edges
`timescale 1ns/1ps

module mdio_frame_engine (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 cmd_valid,
   input  mdio_pkg::mdio_cmd_t  cmd,
   output logic                 busy,
   output mdio_pkg::mdio_data_t rd_data,
   input  logic                 mdc_rise,
   input  logic                 mdc_fall,
   output logic                 mdio_out,
   output logic                 mdio_oe,
   input  logic                 mdio_in
);

   localparam int cnt_w = $clog2(mdio_pkg::frame_bits);

   typedef enum logic [1:0] {
      eng_idle,
      eng_start,
      eng_run
   } eng_state_e;

   eng_state_e            state;
   mdio_pkg::mdio_cmd_t   cmd_q;
   mdio_pkg::mdio_frame_t frame_sr;
   mdio_pkg::mdio_frame_t oe_sr;
   logic [cnt_w-1:0]      bit_cnt;

   logic                  load_frame;
   logic                  shift_frame;
   logic                  last_bit;
   logic                  sample_bit;
   mdio_pkg::mdio_frame_t frame_img;
   mdio_pkg::mdio_frame_t oe_img;

   // Busy rises in the same cycle the command is seen
   assign busy = (state != eng_idle) || cmd_valid;

   // Frame starts on the first MDC fall after the command
   assign load_frame  = (state == eng_start) && mdc_fall;
   assign shift_frame = (state == eng_run) && mdc_fall;
   assign last_bit    = (bit_cnt == '0);

   // Read data occupies the last 16 bit slots
   assign sample_bit = (state == eng_run) && mdc_rise &&
                       (cmd_q.op == mdio_pkg::op_read) &&
                       (bit_cnt < cnt_w'(mdio_pkg::data_bits));

   // Wire image of the frame
   // Turnaround and data are don't-care on reads, the enable mask hides them
   assign frame_img = {mdio_pkg::start_code,
                       cmd_q.op,
                       3'b000,
                       cmd_q.phy,
                       cmd_q.regnum,
                       mdio_pkg::ta_write,
                       cmd_q.wdata};

   // Writes drive the whole frame
   // Reads release the line from turnaround on
   assign oe_img = (cmd_q.op == mdio_pkg::op_write) ? '1 :
                   {{mdio_pkg::hdr_bits{1'b1}},
                    {(mdio_pkg::frame_bits - mdio_pkg::hdr_bits){1'b0}}};

   // Control FSM
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= eng_idle;
      end else begin
         case (state)
            eng_idle: begin
               if (cmd_valid) begin
                  state <= eng_start;
               end
            end
            eng_start: begin
               if (mdc_fall) begin
                  state <= eng_run;
               end
            end
            eng_run: begin
               // The fall that closes bit 31 ends the frame
               if (mdc_fall && last_bit) begin
                  state <= eng_idle;
               end
            end
            default: begin
               state <= eng_idle;
            end
         endcase
      end
   end

   // Command capture, only accepted while idle
   always_ff @(posedge clk) begin
      if (state == eng_idle && cmd_valid) begin
         cmd_q <= cmd;
      end
   end

   // Data and enable shifters, MSB on the pin
   // Both drain to zero by the end of the frame
   always_ff @(posedge clk) begin
      if (reset) begin
         frame_sr <= '0;
         oe_sr    <= '0;
      end else if (load_frame) begin
         frame_sr <= frame_img;
         oe_sr    <= oe_img;
      end else if (shift_frame) begin
         frame_sr <= {frame_sr[mdio_pkg::frame_bits-2:0], 1'b0};
         oe_sr    <= {oe_sr[mdio_pkg::frame_bits-2:0], 1'b0};
      end
   end

   // Bit slots left in the frame
   always_ff @(posedge clk) begin
      if (reset) begin
         bit_cnt <= '0;
      end else if (load_frame) begin
         bit_cnt <= cnt_w'(mdio_pkg::frame_bits - 1);
      end else if (shift_frame && !last_bit) begin
         bit_cnt <= bit_cnt - 1'b1;
      end
   end

   // Read data, MSB first off the wire
   // Left alone outside a read frame so it holds while idle
   always_ff @(posedge clk) begin
      if (sample_bit) begin
         rd_data <= {rd_data[mdio_pkg::data_bits-2:0], mdio_in};
      end
   end

   assign mdio_out = frame_sr[mdio_pkg::frame_bits-1];
   assign mdio_oe  = oe_sr[mdio_pkg::frame_bits-1];

endmodule

// ==== src/mdio_pkg.sv ====
// MDIO clause-22 frame definitions
// Field types, opcode encoding, command struct and frame layout constants
package mdio_pkg;

   // Field types
   typedef logic [1:0]  phy_sel_t;
   typedef logic [4:0]  phy_regnum_t;
   typedef logic [15:0] mdio_data_t;
   typedef logic [31:0] mdio_frame_t;

   // Opcode as it appears on the wire
   typedef enum logic [1:0] {
      op_write = 2'b01,
      op_read  = 2'b10
   } mdio_op_e;

   // Command handed from the register glue to the frame engine
   typedef struct packed {
      mdio_op_e    op;
      phy_sel_t    phy;
      phy_regnum_t regnum;
      mdio_data_t  wdata;
   } mdio_cmd_t;

   // Frame layout, no preamble
   localparam int frame_bits = 32;
   // Start, opcode, zero pad, PHY select and register number
   localparam int hdr_bits   = 14;
   localparam int data_bits  = 16;

   localparam logic [1:0] start_code = 2'b01;
   // Turnaround driven by the controller on writes only
   localparam logic [1:0] ta_write   = 2'b10;

endpackage

// ==== src/phy_mgmt_top.sv ====
// PHY management top level
// Register glue, MDC generator and MDIO frame engine
`timescale 1ns/1ps

module phy_mgmt_top #(
   parameter int mdc_half = 5
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   req,
   input  phy_reg_pkg::reg_req_t  reg_req,
   output logic                   ack,
   output phy_reg_pkg::reg_data_t rd_data,
   output logic                   mdc,
   output logic                   mdio_out,
   output logic                   mdio_oe,
   input  logic                   mdio_in
);

   // Glue to engine
   logic                 cmd_valid;
   mdio_pkg::mdio_cmd_t  cmd;
   logic                 busy;
   mdio_pkg::mdio_data_t eng_rd_data;

   // MDC edge strobes
   logic                 mdc_rise;
   logic                 mdc_fall;

   phy_reg_glue u_glue (
      .clk         (clk),
      .reset       (reset),
      .req         (req),
      .reg_req     (reg_req),
      .ack         (ack),
      .rd_data     (rd_data),
      .cmd_valid   (cmd_valid),
      .cmd         (cmd),
      .busy        (busy),
      .eng_rd_data (eng_rd_data)
   );

   mdc_clock_gen #(
      .mdc_half (mdc_half)
   ) u_mdc (
      .clk      (clk),
      .reset    (reset),
      .mdc      (mdc),
      .mdc_rise (mdc_rise),
      .mdc_fall (mdc_fall)
   );

   mdio_frame_engine u_engine (
      .clk       (clk),
      .reset     (reset),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .busy      (busy),
      .rd_data   (eng_rd_data),
      .mdc_rise  (mdc_rise),
      .mdc_fall  (mdc_fall),
      .mdio_out  (mdio_out),
      .mdio_oe   (mdio_oe),
      .mdio_in   (mdio_in)
   );

endmodule

// ==== src/phy_reg_glue.sv ====
// Register-bus front end for the MDIO engine
// Decodes the address, issues one command at a time and returns the ack
`timescale 1ns/1ps

module phy_reg_glue (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  req,
   input  phy_reg_pkg::reg_req_t reg_req,
   output logic                  ack,
   output phy_reg_pkg::reg_data_t rd_data,
   output logic                  cmd_valid,
   output mdio_pkg::mdio_cmd_t   cmd,
   input  logic                  busy,
   input  mdio_pkg::mdio_data_t  eng_rd_data
);

   typedef enum logic [1:0] {
      glue_idle,
      glue_wait_phy,
      glue_wait_release
   } glue_state_e;

   glue_state_e         state;
   logic                rd_q;
   logic                addr_ok;
   mdio_pkg::mdio_cmd_t cmd_img;

   // Addresses past the four PHYs get the error word
   assign addr_ok = (reg_req.addr < phy_reg_pkg::num_phy_regs);

   // Bits 6:5 pick the PHY, 4:0 the register
   // Only the low 16 write bits reach the wire
   assign cmd_img.op     = reg_req.rd ? mdio_pkg::op_read : mdio_pkg::op_write;
   assign cmd_img.phy    = mdio_pkg::phy_sel_t'(reg_req.addr[6:5]);
   assign cmd_img.regnum = mdio_pkg::phy_regnum_t'(reg_req.addr[4:0]);
   assign cmd_img.wdata  = reg_req.wdata[15:0];

   // Control FSM with single-cycle ack and command strobes
   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= glue_idle;
         ack       <= 1'b0;
         cmd_valid <= 1'b0;
      end else begin
         ack       <= 1'b0;
         cmd_valid <= 1'b0;
         case (state)
            glue_idle: begin
               // Requests wait here while a frame is still on the wire
               if (req && !busy) begin
                  if (addr_ok) begin
                     cmd_valid <= 1'b1;
                     state     <= glue_wait_phy;
                  end else begin
                     ack   <= 1'b1;
                     state <= glue_wait_release;
                  end
               end
            end
            glue_wait_phy: begin
               // Engine holds busy from the cmd_valid cycle on
               if (!busy) begin
                  ack   <= 1'b1;
                  state <= glue_wait_release;
               end
            end
            glue_wait_release: begin
               if (!req) begin
                  state <= glue_idle;
               end
            end
            default: begin
               state <= glue_idle;
            end
         endcase
      end
   end

   // Command and request type, captured when the command goes out
   always_ff @(posedge clk) begin
      if (state == glue_idle && req && !busy && addr_ok) begin
         cmd  <= cmd_img;
         rd_q <= reg_req.rd;
      end
   end

   // Read data, valid in the ack cycle
   always_ff @(posedge clk) begin
      if (state == glue_idle && req && !busy && !addr_ok) begin
         rd_data <= phy_reg_pkg::bad_addr_data;
      end else if (state == glue_wait_phy && !busy) begin
         // Engine data is stable once busy is low
         if (rd_q) begin
            rd_data <= {16'h0000, eng_rd_data};
         end else begin
            rd_data <= '0;
         end
      end
   end

endmodule

// ==== src/phy_reg_pkg.sv ====
// Register-bus definitions for the PHY management block
// Address and data types, request bundle and address map constants
package phy_reg_pkg;

   typedef logic [7:0]  reg_addr_t;
   typedef logic [31:0] reg_data_t;

   // Single request, held by the requester until ack
   typedef struct packed {
      logic      rd;
      reg_addr_t addr;
      reg_data_t wdata;
   } reg_req_t;

   // Four PHYs with 32 registers each
   localparam int num_phy_regs = 128;

   // Returned for any address outside the PHY window
   localparam reg_data_t bad_addr_data = 32'hDEAD_BEEF;

endpackage
